//--- Makefile
TOP := tb_padring

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f padring.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module padring -f padring.f

clean:
	rm -rf obj_dir sim.log

//--- padring.f
src/padring_pkg.sv
src/pinmux_regs.sv
src/pinmux_out_mux.sv
src/pad_model.sv
src/pinmux_in_route.sv
src/padring.sv
verification/tb_clk_gen.sv
verification/tb_padring.sv

//--- src/pad_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral model of one MIO pad with
// drive, pulls and input processing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pad_model (
  input  logic                  clk_i,
  input  logic                  out_i,
  input  logic                  oe_i,
  input  padring_pkg::pad_attr_t attr_i,
  input  logic                  ext_i,
  input  logic                  ext_en_i,
  output logic                  pad_o,
  output logic                  pad_oe_o,
  output logic                  in_o,
  output logic                  in_raw_o
);

  logic out_lvl;
  logic drive;
  logic pad_lvl;

  assign out_lvl = out_i ^ attr_i.invert;

  // In open drain mode a high level is left to the pull or the board.
  assign drive = oe_i & ~(attr_i.od_en & out_lvl);

  assign pad_o    = out_lvl;
  assign pad_oe_o = drive;

  // The chip wins over the board, then the pull.
  // A floating pad reads as 0.
  always_comb begin
    if (drive) begin
      pad_lvl = out_lvl;
    end else if (ext_en_i) begin
      pad_lvl = ext_i;
    end else if (attr_i.pull_en) begin
      pad_lvl = attr_i.pull_sel;
    end else begin
      pad_lvl = 1'b0;
    end
  end

  assign in_raw_o = pad_lvl;
  assign in_o     = attr_i.input_disable ? 1'b0 : (pad_lvl ^ attr_i.invert);

  // Chip and board fighting over the pad with opposite levels.
  DriveConflict_A: assert property (@(posedge clk_i)
    drive && ext_en_i |-> ext_i == out_lvl);

endmodule : pad_model

//--- src/padring.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIO pad ring top: pinmux registers,
// output mux, pad models and input routing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module padring #(
  parameter int NMioPads   = 4,
  parameter int NPeriphOut = 4,
  parameter int NPeriphIn  = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Configuration port
  input  logic                  cfg_valid_i,
  output logic                  cfg_ready_o,
  input  padring_pkg::cfg_req_t cfg_req_i,
  // Peripheral side
  input  logic [NPeriphOut-1:0] periph_out_i,
  input  logic [NPeriphOut-1:0] periph_oe_i,
  output logic [NPeriphIn-1:0]  periph_in_o,
  // Pad side, split into chip drive and board drive
  output logic [NMioPads-1:0]   pad_o,
  output logic [NMioPads-1:0]   pad_oe_o,
  output logic [NMioPads-1:0]   pad_in_raw_o,
  input  logic [NMioPads-1:0]   pad_ext_i,
  input  logic [NMioPads-1:0]   pad_ext_en_i
);
  import padring_pkg::*;

  sel_t      [NMioPads-1:0]  pad_sel;
  pad_attr_t [NMioPads-1:0]  pad_attr;
  sel_t      [NPeriphIn-1:0] in_sel;
  logic      [NMioPads-1:0]  mux_out;
  logic      [NMioPads-1:0]  mux_oe;
  logic      [NMioPads-1:0]  pad_in;

  pinmux_regs #(
    .NMioPads   ( NMioPads   ),
    .NPeriphOut ( NPeriphOut ),
    .NPeriphIn  ( NPeriphIn  )
  ) u_pinmux_regs (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_valid_i ( cfg_valid_i ),
    .cfg_ready_o ( cfg_ready_o ),
    .cfg_req_i   ( cfg_req_i   ),
    .pad_sel_o   ( pad_sel     ),
    .pad_attr_o  ( pad_attr    ),
    .in_sel_o    ( in_sel      )
  );

  pinmux_out_mux #(
    .NMioPads   ( NMioPads   ),
    .NPeriphOut ( NPeriphOut )
  ) u_pinmux_out_mux (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .periph_out_i ( periph_out_i ),
    .periph_oe_i  ( periph_oe_i  ),
    .pad_sel_i    ( pad_sel      ),
    .mux_out_o    ( mux_out      ),
    .mux_oe_o     ( mux_oe       )
  );

  for (genvar k = 0; k < NMioPads; k++) begin : gen_mio_pads
    pad_model u_pad (
      .clk_i    ( clk_i           ),
      .out_i    ( mux_out[k]      ),
      .oe_i     ( mux_oe[k]       ),
      .attr_i   ( pad_attr[k]     ),
      .ext_i    ( pad_ext_i[k]    ),
      .ext_en_i ( pad_ext_en_i[k] ),
      .pad_o    ( pad_o[k]        ),
      .pad_oe_o ( pad_oe_o[k]     ),
      .in_o     ( pad_in[k]       ),
      .in_raw_o ( pad_in_raw_o[k] )
    );
  end

  pinmux_in_route #(
    .NMioPads  ( NMioPads  ),
    .NPeriphIn ( NPeriphIn )
  ) u_pinmux_in_route (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .pad_in_i    ( pad_in      ),
    .in_sel_i    ( in_sel      ),
    .periph_in_o ( periph_in_o )
  );

  ParamRange_A: assert property (@(posedge clk_i)
    NMioPads <= MaxSel && NPeriphOut <= MaxSel && NPeriphIn <= MaxSel);

endmodule : padring

//--- src/padring_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad ring shared types: selection widths, pad attributes
// and the configuration write request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package padring_pkg;

  // Selection index. Zero means no source, value k selects item k-1.
  parameter int SelW = 4;
  typedef logic [SelW-1:0] sel_t;

  // Largest item count that a selection index can address.
  parameter int MaxSel = 2**SelW - 1;

  // Index of the pad or peripheral input that a write targets.
  parameter int IdxW = 4;
  typedef logic [IdxW-1:0] idx_t;

  // Per-pad electrical attributes.
  typedef struct packed {
    logic invert;         // Inverts output and processed input.
    logic od_en;          // Open drain, drive only a low level.
    logic pull_en;
    logic pull_sel;       // 1 for pull-up, 0 for pull-down.
    logic input_disable;  // Forces the processed input low.
  } pad_attr_t;

  typedef enum logic {
    CfgPad      = 1'b0,
    CfgPeriphIn = 1'b1
  } cfg_target_e;

  // One configuration write. The attribute field only applies to pads.
  typedef struct packed {
    cfg_target_e target;
    idx_t        index;
    sel_t        sel;
    pad_attr_t   attr;
  } cfg_req_t;

endpackage : padring_pkg

//--- src/pinmux_in_route.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad input synchronizer and routing
// to the peripheral inputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pinmux_in_route #(
  parameter int NMioPads  = 4,
  parameter int NPeriphIn = 4
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic              [NMioPads-1:0]  pad_in_i,
  input  padring_pkg::sel_t [NPeriphIn-1:0] in_sel_i,
  output logic              [NPeriphIn-1:0] periph_in_o
);
  import padring_pkg::*;

  logic [NMioPads-1:0] sync_q1;
  logic [NMioPads-1:0] sync_q2;

  // Pad levels are asynchronous to clk_i, so two flops come first.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // The mux sits after the synchronizer, so a new selection acts
  // on already synchronized data without extra delay.
  always_comb begin
    periph_in_o = '0;
    for (int i = 0; i < NPeriphIn; i++) begin
      for (int p = 0; p < NMioPads; p++) begin
        if (in_sel_i[i] == sel_t'(p + 1)) begin
          periph_in_o[i] = sync_q2[p];
        end
      end
    end
  end

  ParamRange_A: assert property (@(posedge clk_i)
    NMioPads <= MaxSel && NPeriphIn <= MaxSel);

  for (genvar i = 0; i < NPeriphIn; i++) begin : gen_sel_check
    // Selections past the last pad are clipped before they reach here.
    SelInRange_A: assert property (@(posedge clk_i) disable iff (reset_i)
      int'(in_sel_i[i]) <= NMioPads);
  end

endmodule : pinmux_in_route

//--- src/pinmux_out_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered output mux from peripheral outputs to pads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pinmux_out_mux #(
  parameter int NMioPads   = 4,
  parameter int NPeriphOut = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic              [NPeriphOut-1:0] periph_out_i,
  input  logic              [NPeriphOut-1:0] periph_oe_i,
  input  padring_pkg::sel_t [NMioPads-1:0]   pad_sel_i,
  output logic              [NMioPads-1:0]   mux_out_o,
  output logic              [NMioPads-1:0]   mux_oe_o
);
  import padring_pkg::*;

  logic [NMioPads-1:0] out_d;
  logic [NMioPads-1:0] oe_d;

  // A pad with no selection keeps both level and enable low.
  always_comb begin
    out_d = '0;
    oe_d  = '0;
    for (int p = 0; p < NMioPads; p++) begin
      for (int k = 0; k < NPeriphOut; k++) begin
        if (pad_sel_i[p] == sel_t'(k + 1)) begin
          out_d[p] = periph_out_i[k];
          oe_d[p]  = periph_oe_i[k];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mux_out_o <= '0;
      mux_oe_o  <= '0;
    end else begin
      mux_out_o <= out_d;
      mux_oe_o  <= oe_d;
    end
  end

  ParamRange_A: assert property (@(posedge clk_i)
    NMioPads <= MaxSel && NPeriphOut <= MaxSel);

  for (genvar p = 0; p < NMioPads; p++) begin : gen_oe_check
    // An unselected pad must be released on the next cycle.
    NoSelNoOe_A: assert property (@(posedge clk_i) disable iff (reset_i)
      pad_sel_i[p] == '0 |=> !mux_oe_o[p]);
  end

endmodule : pinmux_out_mux

//--- src/pinmux_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pinmux configuration registers
// written through a valid/ready port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pinmux_regs #(
  parameter int NMioPads   = 4,
  parameter int NPeriphOut = 4,
  parameter int NPeriphIn  = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  cfg_valid_i,
  output logic                                  cfg_ready_o,
  input  padring_pkg::cfg_req_t                 cfg_req_i,
  output padring_pkg::sel_t      [NMioPads-1:0]  pad_sel_o,
  output padring_pkg::pad_attr_t [NMioPads-1:0]  pad_attr_o,
  output padring_pkg::sel_t      [NPeriphIn-1:0] in_sel_o
);
  import padring_pkg::*;

  logic cfg_we;
  sel_t pad_sel_clip;
  sel_t in_sel_clip;

  assign cfg_we = cfg_valid_i & cfg_ready_o;

  // Selections that point past the last source fall back to "none".
  assign pad_sel_clip = (int'(cfg_req_i.sel) > NPeriphOut) ? '0 : cfg_req_i.sel;
  assign in_sel_clip  = (int'(cfg_req_i.sel) > NMioPads) ? '0 : cfg_req_i.sel;

  // The port never stalls, ready only drops during reset.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_ready_o <= 1'b0;
    end else begin
      cfg_ready_o <= 1'b1;
    end
  end

  // Indices with no matching entry simply match nothing and are dropped.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pad_sel_o  <= '0;
      pad_attr_o <= '0;
      in_sel_o   <= '0;
    end else if (cfg_we) begin
      if (cfg_req_i.target == CfgPad) begin
        for (int k = 0; k < NMioPads; k++) begin
          if (cfg_req_i.index == idx_t'(k)) begin
            pad_sel_o[k]  <= pad_sel_clip;
            pad_attr_o[k] <= cfg_req_i.attr;
          end
        end
      end else begin
        for (int k = 0; k < NPeriphIn; k++) begin
          if (cfg_req_i.index == idx_t'(k)) begin
            in_sel_o[k] <= in_sel_clip;
          end
        end
      end
    end
  end

  // Every item must be reachable by a selection index.
  ParamRange_A: assert property (@(posedge clk_i)
    NMioPads <= MaxSel && NPeriphOut <= MaxSel && NPeriphIn <= MaxSel);

  // A request held back by the port must not change before it is taken.
  ReqStable_A: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_valid_i && !cfg_ready_o |=> $stable(cfg_req_i));

endmodule : pinmux_regs

//--- verification/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic reset_o
);

  // 10 ns period.
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : tb_clk_gen

//--- verification/tb_padring.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the MIO pad ring.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_padring;
  import padring_pkg::*;

  localparam int NPads = 4;
  localparam int NOut = 4;
  localparam int NIn = 4;
  localparam int TimeoutCycles = 2000;

  logic clk;
  logic reset;
  logic cfg_valid;
  logic cfg_ready;
  cfg_req_t cfg_req;
  logic [NOut-1:0] periph_out;
  logic [NOut-1:0] periph_oe;
  logic [NIn-1:0] periph_in;
  logic [NPads-1:0] pad_out;
  logic [NPads-1:0] pad_oe;
  logic [NPads-1:0] pad_raw;
  logic [NPads-1:0] pad_ext;
  logic [NPads-1:0] pad_ext_en;

  logic [31:0] rng_state = 32'h4ff3_4167;
  int cycles = 0;
  int err_count = 0;
  int errs_before = 0;
  int tests_run = 0;
  int tests_failed = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  padring dut (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .cfg_valid_i  ( cfg_valid  ),
    .cfg_ready_o  ( cfg_ready  ),
    .cfg_req_i    ( cfg_req    ),
    .periph_out_i ( periph_out ),
    .periph_oe_i  ( periph_oe  ),
    .periph_in_o  ( periph_in  ),
    .pad_o        ( pad_out    ),
    .pad_oe_o     ( pad_oe     ),
    .pad_in_raw_o ( pad_raw    ),
    .pad_ext_i    ( pad_ext    ),
    .pad_ext_en_i ( pad_ext_en )
  );

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic cfg_req_t make_req(cfg_target_e target, int index, int sel,
                                        pad_attr_t attr);
    cfg_req_t req;
    req.target = target;
    req.index  = idx_t'(index);
    req.sel    = sel_t'(sel);
    req.attr   = attr;
    return req;
  endfunction

  task automatic check_bit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_vec(string name, logic [NPads-1:0] actual, logic [NPads-1:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // One request through the handshake, held until ready is seen.
  task automatic cfg_write(cfg_req_t req);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_req   <= req;
    @(posedge clk);
    while (!cfg_ready) @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  // Waits n rising edges, then moves to the falling edge where outputs are stable.
  task automatic settle(int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (err_count == errs_before) begin
      $display("Test %s passed.", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors.", name, err_count - errs_before);
    end
    errs_before = err_count;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("cfg_ready_o", cfg_ready, 1'b0);
    wait (!reset);
    settle(1);
    check_bit("cfg_ready_o", cfg_ready, 1'b1);
    check_vec("pad_oe_o", pad_oe, '0);
    check_vec("periph_in_o", periph_in, '0);
    end_test("reset state");
  endtask

  task automatic test_out_routing();
    int sel [NPads];
    logic [NOut-1:0] data;
    logic [NOut-1:0] en;
    logic [NPads-1:0] exp_out;
    logic [NPads-1:0] exp_oe;
    // The last pad keeps no selection and must stay undriven.
    for (int p = 0; p < NPads; p++) begin
      sel[p] = (p == NPads - 1) ? 0 : int'(lcg_next() % NOut) + 1;
      cfg_write(make_req(CfgPad, p, sel[p], '0));
    end
    for (int n = 0; n < 4; n++) begin
      data = NOut'(lcg_next());
      en   = NOut'(lcg_next());
      @(posedge clk);
      periph_out <= data;
      periph_oe  <= en;
      settle(1);
      exp_out = '0;
      exp_oe  = '0;
      for (int p = 0; p < NPads; p++) begin
        if (sel[p] != 0) begin
          exp_out[p] = data[sel[p] - 1];
          exp_oe[p]  = en[sel[p] - 1];
        end
      end
      check_vec("pad_o", pad_out, exp_out);
      check_vec("pad_oe_o", pad_oe, exp_oe);
    end
    end_test("output routing");
  endtask

  task automatic test_out_attr();
    pad_attr_t attr;
    logic lvl;
    // Pad 0 follows peripheral 0, inverted, first push-pull then open drain.
    for (int k = 0; k < 4; k++) begin
      attr = '0;
      attr.invert = 1'b1;
      attr.od_en  = k[1];
      cfg_write(make_req(CfgPad, 0, 1, attr));
      @(posedge clk);
      periph_out[0] <= k[0];
      periph_oe[0]  <= 1'b1;
      settle(1);
      lvl = ~k[0];
      check_bit("pad_o[0]", pad_out[0], lvl);
      check_bit("pad_oe_o[0]", pad_oe[0], !(attr.od_en && lvl));
    end
    end_test("output attributes");
  endtask

  task automatic test_in_routing();
    int sel [NIn];
    logic [NPads-1:0] data;
    logic [NIn-1:0] exp_in;
    // Release every pad so that only the board drives them.
    for (int p = 0; p < NPads; p++) begin
      cfg_write(make_req(CfgPad, p, 0, '0));
    end
    for (int i = 0; i < NIn; i++) begin
      sel[i] = int'(lcg_next() % NPads) + 1;
      cfg_write(make_req(CfgPeriphIn, i, sel[i], '0));
    end
    for (int n = 0; n < 6; n++) begin
      data = NPads'(lcg_next());
      @(posedge clk);
      pad_ext_en <= '1;
      pad_ext    <= data;
      @(negedge clk);
      check_vec("pad_in_raw_o", pad_raw, data);
      settle(2);
      for (int i = 0; i < NIn; i++) begin
        exp_in[i] = data[sel[i] - 1];
      end
      check_vec("periph_in_o", periph_in, exp_in);
    end
    end_test("input routing");
  endtask

  task automatic test_in_attr();
    pad_attr_t attr;
    logic exp_in;
    @(posedge clk);
    pad_ext_en <= '0;
    cfg_write(make_req(CfgPeriphIn, 0, 1, '0));
    // Pad 0 floats, so the pull alone sets its level.
    for (int k = 0; k < 8; k++) begin
      attr = '0;
      attr.pull_en       = 1'b1;
      attr.pull_sel      = k[0];
      attr.invert        = k[1];
      attr.input_disable = k[2];
      cfg_write(make_req(CfgPad, 0, 0, attr));
      settle(2);
      exp_in = attr.input_disable ? 1'b0 : (attr.pull_sel ^ attr.invert);
      check_bit("pad_in_raw_o[0]", pad_raw[0], attr.pull_sel);
      check_bit("periph_in_o[0]", periph_in[0], exp_in);
    end
    end_test("input attributes and pulls");
  endtask

  task automatic test_out_of_range();
    pad_attr_t attr;
    logic [NPads-1:0] ext;
    logic [NIn-1:0] exp_in;
    attr = '0;
    attr.invert = 1'b1;
    ext = 4'b0110;
    // Known routing first: inputs 0 to 3 read pads 0, 1, 3 and 2.
    cfg_write(make_req(CfgPad, 0, 0, '0));
    cfg_write(make_req(CfgPeriphIn, 0, 1, '0));
    cfg_write(make_req(CfgPeriphIn, 1, 2, '0));
    cfg_write(make_req(CfgPeriphIn, 2, 4, '0));
    cfg_write(make_req(CfgPeriphIn, 3, 3, '0));
    @(posedge clk);
    periph_out <= '1;
    periph_oe  <= '1;
    pad_ext_en <= '1;
    pad_ext    <= ext;
    cfg_write(make_req(CfgPad, 1, NOut + 5, '0));
    // A wrapped index would land on pad 1 or input 0 and change them.
    cfg_write(make_req(CfgPad, NPads + 5, 1, attr));
    cfg_write(make_req(CfgPeriphIn, NIn + 8, 2, '0));
    // The last input gets a pad beyond range and falls back to no source.
    cfg_write(make_req(CfgPeriphIn, NIn - 1, NPads + 3, '0));
    settle(1);
    exp_in = '0;
    exp_in[0] = ext[0];
    exp_in[1] = ext[1];
    exp_in[2] = ext[3];
    check_vec("pad_o", pad_out, '0);
    check_vec("pad_oe_o", pad_oe, '0);
    check_vec("pad_in_raw_o", pad_raw, ext);
    check_vec("periph_in_o", periph_in, exp_in);
    end_test("out of range selections");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles.", TimeoutCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    cfg_valid  <= 1'b0;
    cfg_req    <= '0;
    periph_out <= '0;
    periph_oe  <= '0;
    pad_ext    <= '0;
    pad_ext_en <= '0;
    test_reset();
    test_out_routing();
    test_out_attr();
    test_in_routing();
    test_in_attr();
    test_out_of_range();
    $display("Tests run: %0d, failed: %0d, failed checks: %0d.",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_padring
